/* logic/gpio_lite_pkg.sv */
`default_nettype none

package gpio_lite_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int gpio_width      = 16;  // pins
  localparam int gpio_addr_width = 6;   // register address bits

  typedef logic [gpio_width-1:0]      gpio_vec_t;   // one bit per pin
  typedef logic [gpio_addr_width-1:0] gpio_addr_t;  // register offset

  // --------------------
  // register offsets
  // --------------------
  localparam gpio_addr_t gpr_direction_mode = 6'h04;  // 1 = input, 0 = output
  localparam gpio_addr_t gpr_output_enable  = 6'h08;  // per pin drive enable
  localparam gpio_addr_t gpr_output_value   = 6'h0C;  // value driven on pin_out
  localparam gpio_addr_t gpr_input_value    = 6'h10;  // synchronized pins, ro
  localparam gpio_addr_t gpr_int_status     = 6'h20;  // sticky rise flags, read clears

  // --------------------
  // reset values
  // --------------------
  // all pins come up as outputs with drivers off
  localparam gpio_vec_t gprv_direction_mode = 16'h0000;
  localparam gpio_vec_t gprv_output_enable  = 16'h0000;  // tri-stated
  localparam gpio_vec_t gprv_output_value   = 16'h0000;
  localparam gpio_vec_t gprv_input_value    = 16'h0000;  // reads zero until pins settle
  localparam gpio_vec_t gprv_int_status     = 16'h0000;  // nothing pending

endpackage

`default_nettype wire

/* logic/gpio_bus_if.sv */
`default_nettype none

// register bus between the APB decoder and the register block
interface gpio_bus_if;

  import gpio_lite_pkg::*;

  logic       read;   // one cycle pulse
  logic       write;  // one cycle pulse
  gpio_addr_t addr;   // register offset
  gpio_vec_t  wdata;  // write data
  gpio_vec_t  rdata;  // registered, zero when no read

  // decoder side
  modport master (
    output read,
    output write,
    output addr,
    output wdata,
    input  rdata
  );

  // register block side
  modport slave (
    input  read,
    input  write,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* logic/gpio_apb_decoder.sv */
`default_nettype none

module gpio_apb_decoder (
  input  wire logic                     pclk20,
  input  wire logic                     n_reset20,  // async, active low
  input  wire logic                     psel,
  input  wire logic                     penable,
  input  wire logic                     pwrite,
  input  wire gpio_lite_pkg::gpio_addr_t paddr,
  input  wire gpio_lite_pkg::gpio_vec_t  pwdata,
  output      gpio_lite_pkg::gpio_vec_t  prdata,
  gpio_bus_if.master                    bus
);

  logic setup_q;  // setup phase seen on the last edge

  // --------------------
  // phase tracking
  // --------------------
  // an access phase only counts when it directly follows a setup phase,
  // so penable held high across cycles gives one write and no more
  always_ff @(posedge pclk20 or negedge n_reset20)
  begin
    if (!n_reset20)
      setup_q <= 1'b0;
    else
      setup_q <= psel & ~penable;
  end

  // --------------------
  // strobes
  // --------------------
  // read in setup so the registered rdata lands in the access phase
  assign bus.read  = psel & ~penable & ~pwrite;
  // write in access, register updates at its closing edge
  assign bus.write = psel & penable & pwrite & setup_q;

  assign bus.addr  = paddr;   // stable for the whole transfer
  assign bus.wdata = pwdata;
  assign prdata    = bus.rdata;  // already zero outside a read

  // --------------------
  // checks
  // --------------------
  // master protocol, access phase never without select
  a_penable_needs_psel : assert property (
    @(posedge pclk20) disable iff (!n_reset20)
    penable |-> psel
  );

endmodule

`default_nettype wire

/* logic/gpio_pin_sync.sv */
`default_nettype none

module gpio_pin_sync (
  input  wire logic                    pclk20,
  input  wire logic                    n_reset20,  // async, active low
  input  wire gpio_lite_pkg::gpio_vec_t pin_in,     // asynchronous pins
  output      gpio_lite_pkg::gpio_vec_t synced,     // second flop of the chain
  output      gpio_lite_pkg::gpio_vec_t previous    // one sample behind synced
);

  import gpio_lite_pkg::*;

  gpio_vec_t stage_one;  // first flop, may go metastable

  // --------------------
  // sync chain
  // --------------------
  always_ff @(posedge pclk20 or negedge n_reset20)
  begin
    if (!n_reset20)
    begin
      stage_one <= '0;
      synced    <= '0;
      previous  <= gprv_input_value;  // doubles as the input value register
    end
    else
    begin
      stage_one <= pin_in;
      synced    <= stage_one;  // safe to use from here on
      previous  <= synced;     // edge detect reference
    end
  end

  // --------------------
  // checks
  // --------------------
  // pins must be driven once out of reset, else the status logic
  // downstream picks up x on the edge detect
  a_no_x_out : assert property (
    @(posedge pclk20) disable iff (!n_reset20)
    !$isunknown({synced, previous})
  );

endmodule

`default_nettype wire

/* logic/gpio_lite_subunit.sv */
`default_nettype none

module gpio_lite_subunit (
  input  wire logic                    pclk20,
  input  wire logic                    n_reset20,      // async, active low
  gpio_bus_if.slave                    bus,
  input  wire gpio_lite_pkg::gpio_vec_t synced,         // current pin sample
  input  wire gpio_lite_pkg::gpio_vec_t previous,       // last pin sample
  input  wire gpio_lite_pkg::gpio_vec_t test_tristate,  // dft, 1 forces oe off
  output      gpio_lite_pkg::gpio_vec_t interrupt,      // one line per pin
  output      gpio_lite_pkg::gpio_vec_t pin_out,
  output      gpio_lite_pkg::gpio_vec_t pin_oe_n        // active low enable
);

  import gpio_lite_pkg::*;

  // programmable registers
  gpio_vec_t direction_mode;  // 1 = input, 0 = output
  gpio_vec_t output_enable;
  gpio_vec_t output_value;
  gpio_vec_t int_status;      // sticky

  gpio_vec_t input_value;     // read back view of the pins
  gpio_vec_t int_event;       // rising edge on an input pin
  gpio_vec_t status_clear;    // whole register on status read

  // address decodes
  logic ad_direction_mode;
  logic ad_output_enable;
  logic ad_output_value;
  logic ad_int_status;

  assign ad_direction_mode = (bus.addr == gpr_direction_mode);
  assign ad_output_enable  = (bus.addr == gpr_output_enable);
  assign ad_output_value   = (bus.addr == gpr_output_value);
  assign ad_int_status     = (bus.addr == gpr_int_status);

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge pclk20 or negedge n_reset20)
  begin
    if (!n_reset20)
    begin
      direction_mode <= gprv_direction_mode;
      output_enable  <= gprv_output_enable;
      output_value   <= gprv_output_value;
    end
    else if (bus.write)
    begin
      if (ad_direction_mode)
        direction_mode <= bus.wdata;
      if (ad_output_enable)
        output_enable <= bus.wdata;
      if (ad_output_value)
        output_value <= bus.wdata;
      // input value and status ignore writes
    end
  end

  // --------------------
  // interrupts
  // --------------------
  assign input_value = previous;  // third sync stage is the register

  // low to high between samples, input pins only
  assign int_event = synced & ~previous & direction_mode;

  assign status_clear = {gpio_width{bus.read & ad_int_status}};

  always_ff @(posedge pclk20 or negedge n_reset20)
  begin
    if (!n_reset20)
      int_status <= gprv_int_status;
    else
      int_status <= (int_status & ~status_clear)  // read to clear
                  | int_event;                     // new event wins
  end

  assign interrupt = int_status;

  // --------------------
  // read mux
  // --------------------
  // rdata sampled on the read pulse, so the status value returned is
  // the one from before the clear takes effect
  always_ff @(posedge pclk20 or negedge n_reset20)
  begin
    if (!n_reset20)
      bus.rdata <= '0;
    else if (bus.read)
    begin
      case (bus.addr)
        gpr_direction_mode : bus.rdata <= direction_mode;
        gpr_output_enable  : bus.rdata <= output_enable;
        gpr_output_value   : bus.rdata <= output_value;
        gpr_int_status     : bus.rdata <= int_status;
        default            : bus.rdata <= input_value;  // incl. unmapped
      endcase
    end
    else
      bus.rdata <= '0;  // zero outside a read
  end

  // --------------------
  // pin drivers
  // --------------------
  assign pin_out = output_value;

  // drive only output pins with enable set, and not in test
  assign pin_oe_n = ~(output_enable & ~direction_mode) | test_tristate;

  // decoder must never overlap the two strobes
  a_rd_wr_exclusive : assert property (
    @(posedge pclk20) disable iff (!n_reset20)
    !(bus.read && bus.write)
  );

endmodule

`default_nettype wire

/* logic/gpio_lite_top.sv */
`default_nettype none

module gpio_lite_top (
  input  wire logic                     pclk20,
  input  wire logic                     n_reset20,      // async, active low

  // apb
  input  wire logic                     psel,
  input  wire logic                     penable,
  input  wire logic                     pwrite,
  input  wire gpio_lite_pkg::gpio_addr_t paddr,
  input  wire gpio_lite_pkg::gpio_vec_t  pwdata,
  output      gpio_lite_pkg::gpio_vec_t  prdata,

  // pins
  input  wire gpio_lite_pkg::gpio_vec_t  pin_in,
  output      gpio_lite_pkg::gpio_vec_t  pin_out,
  output      gpio_lite_pkg::gpio_vec_t  pin_oe_n,

  // dft and interrupts
  input  wire gpio_lite_pkg::gpio_vec_t  test_tristate,
  output      gpio_lite_pkg::gpio_vec_t  interrupt
);

  import gpio_lite_pkg::*;

  gpio_vec_t synced;    // pin sample after sync chain
  gpio_vec_t previous;  // one cycle older

  gpio_bus_if bus0 ();  // decoder to register block

  gpio_apb_decoder u_decoder (
    .pclk20    (pclk20),
    .n_reset20 (n_reset20),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .bus       (bus0.master)
  );

  gpio_pin_sync u_pin_sync (
    .pclk20    (pclk20),
    .n_reset20 (n_reset20),
    .pin_in    (pin_in),
    .synced    (synced),
    .previous  (previous)
  );

  gpio_lite_subunit u_subunit (
    .pclk20        (pclk20),
    .n_reset20     (n_reset20),
    .bus           (bus0.slave),
    .synced        (synced),
    .previous      (previous),
    .test_tristate (test_tristate),
    .interrupt     (interrupt),
    .pin_out       (pin_out),
    .pin_oe_n      (pin_oe_n)
  );

endmodule

`default_nettype wire

/* testbench/gpio_lite_tb.sv */
`default_nettype none

module gpio_lite_tb;

  import gpio_lite_pkg::*;

  // --------------------
  // constants
  // --------------------
  localparam int clk_half        = 10;     // 20 unit period
  localparam int drive_delay     = 2;      // after the rising edge
  localparam int reset_cycles    = 3;
  localparam int max_idle_cycles = 16;     // budget of one idle wait
  localparam int watchdog_time   = 50000;

  // row kinds
  localparam int op_write     = 0;
  localparam int op_read      = 1;  // check prdata
  localparam int op_pins      = 2;
  localparam int op_tristate  = 3;
  localparam int op_idle      = 4;
  localparam int op_check_oe  = 5;  // check pin_oe_n
  localparam int op_check_out = 6;  // check pin_out
  localparam int op_check_irq = 7;  // check interrupt

  localparam gpio_addr_t unmapped_a = 6'h3C;
  localparam gpio_addr_t unmapped_b = 6'h2C;
  localparam gpio_vec_t  all_bits   = 16'hFFFF;

  logic       pclk20;
  logic       n_reset20;
  logic       psel;
  logic       penable;
  logic       pwrite;
  gpio_addr_t paddr;
  gpio_vec_t  pwdata;
  gpio_vec_t  prdata;
  gpio_vec_t  pin_in;
  gpio_vec_t  pin_out;
  gpio_vec_t  pin_oe_n;
  gpio_vec_t  test_tristate;
  gpio_vec_t  interrupt;

  // stimulus table with one entry per row
  int         row_kind[$];
  gpio_addr_t row_addr[$];
  gpio_vec_t  row_data[$];
  gpio_vec_t  row_exp[$];
  gpio_vec_t  row_mask[$];

  int rows_ok;
  int rows_bad;
  int row_idx;

  gpio_lite_top dut0 (
    .pclk20        (pclk20),
    .n_reset20     (n_reset20),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pin_in        (pin_in),
    .pin_out       (pin_out),
    .pin_oe_n      (pin_oe_n),
    .test_tristate (test_tristate),
    .interrupt     (interrupt)
  );

  always #clk_half pclk20 = ~pclk20;

  // --------------------
  // helpers
  // --------------------
  task add_row(input int kind, input gpio_addr_t addr, input gpio_vec_t data,
               input gpio_vec_t exp, input gpio_vec_t mask);
    begin
      row_kind.push_back(kind);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_exp.push_back(exp);
      row_mask.push_back(mask);
    end
  endtask

  function string kind_name(input int kind);
    case (kind)
      op_write     : return "write";
      op_read      : return "read";
      op_pins      : return "pins";
      op_tristate  : return "tristate";
      op_idle      : return "idle";
      op_check_oe  : return "chk_oe";
      op_check_out : return "chk_out";
      default      : return "chk_irq";
    endcase
  endfunction

  // x on the dut side counts as a mismatch
  task compare_value(input string sig, input gpio_vec_t exp, input gpio_vec_t act,
                     input gpio_vec_t mask, output bit ok);
    begin
      ok = 1'b1;
      assert (((act ^ exp) & mask) === '0)
      else
      begin
        $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp & mask, act);
        ok = 1'b0;
      end
    end
  endtask

  // write lands at the closing edge of the access phase
  task apb_write(input gpio_addr_t addr, input gpio_vec_t data);
    begin
      @(posedge pclk20);
      #drive_delay;
      psel    = 1'b1;  // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk20);
      #drive_delay;
      penable = 1'b1;  // access
      @(posedge pclk20);
      #drive_delay;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task apb_read(input gpio_addr_t addr, output gpio_vec_t data);
    begin
      @(posedge pclk20);
      #drive_delay;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge pclk20);
      #drive_delay;
      penable = 1'b1;
      @(negedge pclk20);
      data = prdata;  // stable in mid access phase
      @(posedge pclk20);
      #drive_delay;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task idle_cycles(input int count, output bit ok);
    int waited;
    begin
      waited = 0;
      while (waited < count && waited < max_idle_cycles)
      begin
        @(posedge pclk20);
        waited++;
      end
      ok = (waited == count);
      if (!ok)
        $display("idle wait of %0d cycles ran past its limit of %0d cycles",
                 count, max_idle_cycles);
    end
  endtask

  task run_row(input int idx, output bit ok);
    gpio_vec_t got;
    begin
      ok = 1'b1;
      case (row_kind[idx])
        op_write : apb_write(row_addr[idx], row_data[idx]);
        op_read :
        begin
          apb_read(row_addr[idx], got);
          compare_value("prdata", row_exp[idx], got, row_mask[idx], ok);
        end
        op_pins :
        begin
          @(posedge pclk20);
          #drive_delay;
          pin_in = row_data[idx];
        end
        op_tristate :
        begin
          @(posedge pclk20);
          #drive_delay;
          test_tristate = row_data[idx];
        end
        op_idle : idle_cycles(int'(row_data[idx]), ok);
        op_check_oe :
        begin
          @(negedge pclk20);
          compare_value("pin_oe_n", row_exp[idx], pin_oe_n, row_mask[idx], ok);
        end
        op_check_out :
        begin
          @(negedge pclk20);
          compare_value("pin_out", row_exp[idx], pin_out, row_mask[idx], ok);
        end
        default :
        begin
          @(negedge pclk20);
          compare_value("interrupt", row_exp[idx], interrupt, row_mask[idx], ok);
        end
      endcase
    end
  endtask

  // --------------------
  // stimulus table
  // --------------------
  task build_table;
    begin
      // reset state
      add_row(op_read, gpr_direction_mode, '0, 16'h0000, all_bits);
      add_row(op_read, gpr_output_enable, '0, 16'h0000, all_bits);
      add_row(op_read, gpr_output_value, '0, 16'h0000, all_bits);
      add_row(op_read, gpr_input_value, '0, 16'h0000, all_bits);
      add_row(op_read, gpr_int_status, '0, 16'h0000, all_bits);
      add_row(op_read, unmapped_a, '0, 16'h0000, all_bits);
      add_row(op_check_oe, '0, '0, 16'hFFFF, all_bits);  // all tri-stated
      add_row(op_check_irq, '0, '0, 16'h0000, all_bits);
      // readback with pins 7..4 as inputs
      add_row(op_write, gpr_direction_mode, 16'h00F0, '0, '0);
      add_row(op_write, gpr_output_enable, 16'h0FFF, '0, '0);
      add_row(op_write, gpr_output_value, 16'hA5C3, '0, '0);
      // read only registers keep their value
      add_row(op_write, gpr_int_status, 16'hFFFF, '0, '0);
      add_row(op_write, gpr_input_value, 16'hFFFF, '0, '0);
      add_row(op_read, gpr_direction_mode, '0, 16'h00F0, all_bits);
      add_row(op_read, gpr_output_enable, '0, 16'h0FFF, all_bits);
      add_row(op_read, gpr_output_value, '0, 16'hA5C3, all_bits);
      add_row(op_read, gpr_input_value, '0, 16'h0000, all_bits);
      add_row(op_read, gpr_int_status, '0, 16'h0000, all_bits);
      // pin drivers
      add_row(op_check_out, '0, '0, 16'hA5C3, all_bits);
      add_row(op_check_oe, '0, '0, 16'hF0F0, all_bits);
      add_row(op_tristate, '0, 16'h0003, '0, '0);
      add_row(op_check_oe, '0, '0, 16'hF0F3, all_bits);
      add_row(op_tristate, '0, 16'hFFFF, '0, '0);
      add_row(op_check_oe, '0, '0, 16'hFFFF, all_bits);
      add_row(op_tristate, '0, 16'h0000, '0, '0);
      add_row(op_check_oe, '0, '0, 16'hF0F0, all_bits);
      // input readback with rises only on output pins
      add_row(op_pins, '0, 16'h1204, '0, '0);
      add_row(op_idle, '0, 16'd5, '0, '0);
      add_row(op_read, gpr_input_value, '0, 16'h1204, all_bits);
      add_row(op_read, unmapped_a, '0, 16'h1204, all_bits);
      add_row(op_read, unmapped_b, '0, 16'h1204, all_bits);
      add_row(op_check_irq, '0, '0, 16'h0000, all_bits);
      // rise on input pins 4 and 6
      add_row(op_pins, '0, 16'h1254, '0, '0);
      add_row(op_idle, '0, 16'd5, '0, '0);
      add_row(op_check_irq, '0, '0, 16'h0050, all_bits);
      add_row(op_read, gpr_input_value, '0, 16'h1254, all_bits);
      // neither the fall of pin 4 nor the rise of output pin 0 sets a bit
      add_row(op_pins, '0, 16'h1244, '0, '0);
      add_row(op_idle, '0, 16'd5, '0, '0);
      add_row(op_check_irq, '0, '0, 16'h0050, all_bits);
      add_row(op_pins, '0, 16'h1245, '0, '0);
      add_row(op_idle, '0, 16'd5, '0, '0);
      add_row(op_check_irq, '0, '0, 16'h0050, all_bits);
      // read clears the whole status
      add_row(op_read, gpr_int_status, '0, 16'h0050, all_bits);
      add_row(op_read, gpr_int_status, '0, 16'h0000, all_bits);
      add_row(op_check_irq, '0, '0, 16'h0000, all_bits);
      add_row(op_pins, '0, 16'h12C5, '0, '0);  // pin 7 rises
      add_row(op_idle, '0, 16'd5, '0, '0);
      add_row(op_check_irq, '0, '0, 16'h0080, all_bits);
      add_row(op_read, gpr_int_status, '0, 16'h0080, all_bits);
      add_row(op_read, gpr_int_status, '0, 16'h0000, all_bits);
      add_row(op_read, gpr_direction_mode, '0, 16'h00F0, all_bits);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin : main_seq
    bit ok;
    pclk20        = 1'b0;
    n_reset20     = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    pin_in        = '0;
    test_tristate = '0;
    rows_ok       = 0;
    rows_bad      = 0;
    build_table();
    for (int c = 0; c < reset_cycles; c++)
      @(posedge pclk20);
    #drive_delay;
    n_reset20 = 1'b1;
    for (row_idx = 0; row_idx < row_kind.size(); row_idx++)
    begin
      run_row(row_idx, ok);
      if (ok)
        rows_ok++;
      else
        rows_bad++;
      $display("row %0d %s addr %h data %h : %s", row_idx, kind_name(row_kind[row_idx]),
               row_addr[row_idx], row_data[row_idx], ok ? "ok" : "mismatch");
    end
    $display("rows ok %0d, rows with errors %0d", rows_ok, rows_bad);
    if (rows_bad == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // hang guard
  initial
  begin
    #watchdog_time;
    $display("timeout, the run did not finish within %0d time units", watchdog_time);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* gpio_lite.f */
logic/gpio_lite_pkg.sv
logic/gpio_bus_if.sv
logic/gpio_apb_decoder.sv
logic/gpio_pin_sync.sv
logic/gpio_lite_subunit.sv
logic/gpio_lite_top.sv
testbench/gpio_lite_tb.sv

/* Bender.yml */
package:
  name: gpio_lite

sources:
  - logic/gpio_lite_pkg.sv
  - logic/gpio_bus_if.sv
  - logic/gpio_apb_decoder.sv
  - logic/gpio_pin_sync.sv
  - logic/gpio_lite_subunit.sv
  - logic/gpio_lite_top.sv
  - target: test
    files:
      - testbench/gpio_lite_tb.sv
